/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       := tb_dcache_mem
FILELIST  := tb.f
OBJ_DIR   := obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "NO ERRORS"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* rtl/dcache_arbiter.sv */
// read port arbiter of the data cache memory core
// priority mask and round robin grant, bank and tag request generation,
// word write collision check and the one cycle read pipeline registers

`include "dcache_params.svh"

module dcache_arbiter
  import dcache_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 rst_ni,
  // read ports
  input  port_mask_t           rd_req_i,
  input  port_mask_t           rd_prio_i,
  input  port_mask_t           rd_tag_only_i,
  input  idx_t [`DC_PORTS-1:0] rd_idx_i,
  input  off_t [`DC_PORTS-1:0] rd_off_i,
  input  tag_t [`DC_PORTS-1:0] rd_tag_i,
  output port_mask_t           rd_ack_o,
  // cache line fill
  input  logic                 wr_cl_vld_i,
  input  way_mask_t            wr_cl_we_i,
  input  idx_t                 wr_cl_idx_i,
  input  tag_t                 wr_cl_tag_i,
  input  line_t                wr_cl_data_i,
  input  way_mask_t            wr_vld_bits_i,
  // single word write
  input  way_mask_t            wr_req_i,
  input  idx_t                 wr_idx_i,
  input  off_t                 wr_off_i,
  input  word_t                wr_data_i,
  input  word_be_t             wr_be_i,
  output logic                 wr_ack_o,
  // memories
  dcache_bank_if.ctrl          bank_o,
  dcache_tag_if.ctrl           tag_o,
  // to hit select
  output logic                 cmp_en_o,
  output tag_t                 cmp_tag_o,
  output bank_sel_t            cmp_bank_o
);

  localparam int PORT_W = $clog2(`DC_PORTS);

  function automatic bank_sel_t off2bank(input off_t off);
    return off[`DC_OFF_W-1:`DC_ALIGN];
  endfunction

  port_mask_t      rd_req_prio, rd_req_masked;
  logic [PORT_W-1:0] rr_q, gnt_idx, gnt_q;
  logic            gnt_vld, rd_acked, rd_full, collision;
  bank_sel_t       rd_bank, wr_bank, bank_q;
  logic            cmp_en_q;
  bank_access_e    acc;

  //////////////////////////////
  // arbitration
  //////////////////////////////

  // high prio requests shut out the low prio ones
  assign rd_req_prio   = rd_req_i & rd_prio_i;
  assign rd_req_masked = (|rd_req_prio) ? rd_req_prio : rd_req_i;

  // first masked request at or after the rr pointer
  always_comb begin : p_rr_arb
    int cand;
    gnt_vld = 1'b0;
    gnt_idx = '0;
    for (int i = 0; i < `DC_PORTS; i++) begin
      cand = (int'(rr_q) + i) % `DC_PORTS;
      if (!gnt_vld && rd_req_masked[cand]) begin
        gnt_vld = 1'b1;
        gnt_idx = cand[PORT_W-1:0];
      end
    end
  end

  // a fill holds off every read
  assign rd_acked = gnt_vld & ~wr_cl_vld_i;

  always_comb begin
    rd_ack_o = '0;
    if (rd_acked) begin
      rd_ack_o[gnt_idx] = 1'b1;
    end
  end

  //////////////////////////////
  // access decision
  //////////////////////////////

  assign rd_bank   = off2bank(rd_off_i[gnt_idx]);
  assign wr_bank   = off2bank(wr_off_i);
  assign rd_full   = rd_acked & ~rd_tag_only_i[gnt_idx];
  // tag-only reads leave the data banks free
  assign collision = rd_full & (rd_bank == wr_bank);
  assign wr_ack_o  = ~wr_cl_vld_i & (|wr_req_i) & ~collision;

  always_comb begin
    if (wr_cl_vld_i) begin
      acc = ACC_FILL;
    end else if (rd_acked && wr_ack_o) begin
      acc = ACC_READ_WORD_WRITE;
    end else if (rd_acked) begin
      acc = ACC_READ;
    end else if (wr_ack_o) begin
      acc = ACC_WORD_WRITE;
    end else begin
      acc = ACC_IDLE;
    end
  end

  //////////////////////////////
  // bank and tag requests
  //////////////////////////////

  always_comb begin
    bank_o.req   = '0;
    bank_o.we    = '0;
    bank_o.be    = '0;
    bank_o.idx   = {`DC_BANKS{wr_idx_i}};
    bank_o.wdata = {(`DC_BANKS * `DC_WAYS){wr_data_i}};

    if (acc == ACC_FILL) begin
      bank_o.req = '1;
      bank_o.we  = '1;
      for (int k = 0; k < `DC_BANKS; k++) begin
        bank_o.idx[k] = wr_cl_idx_i;
        for (int j = 0; j < `DC_WAYS; j++) begin
          bank_o.be[k][j]    = wr_cl_we_i[j] ? '1 : '0;
          bank_o.wdata[k][j] = wr_cl_data_i[k*`DC_XLEN +: `DC_XLEN];
        end
      end
    end

    // full reads touch only the bank of their word
    if ((acc == ACC_READ || acc == ACC_READ_WORD_WRITE) && rd_full) begin
      bank_o.req[rd_bank] = 1'b1;
      bank_o.idx[rd_bank] = rd_idx_i[gnt_idx];
    end

    if (acc == ACC_WORD_WRITE || acc == ACC_READ_WORD_WRITE) begin
      bank_o.req[wr_bank] = 1'b1;
      bank_o.we[wr_bank]  = 1'b1;
      for (int j = 0; j < `DC_WAYS; j++) begin
        bank_o.be[wr_bank][j] = wr_req_i[j] ? wr_be_i : '0;
      end
    end
  end

  // every granted read looks up both ways
  assign tag_o.req  = (acc == ACC_FILL) ? wr_cl_we_i : (rd_acked ? '1 : '0);
  assign tag_o.we   = (acc == ACC_FILL);
  assign tag_o.addr = (acc == ACC_FILL) ? wr_cl_idx_i : rd_idx_i[gnt_idx];
  assign tag_o.wtag = wr_cl_tag_i;
  assign tag_o.wvld = wr_vld_bits_i;

  //////////////////////////////
  // pipeline registers
  //////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rr_q     <= '0;
      gnt_q    <= '0;
      bank_q   <= '0;
      cmp_en_q <= 1'b0;
    end else begin
      cmp_en_q <= rd_acked;
      if (rd_acked) begin
        gnt_q  <= gnt_idx;
        bank_q <= rd_bank;
        if (gnt_idx == PORT_W'(`DC_PORTS - 1)) begin
          rr_q <= '0;
        end else begin
          rr_q <= gnt_idx + 1'b1;
        end
      end
    end
  end

  // the tag of the granted port arrives one cycle late
  assign cmp_en_o   = cmp_en_q;
  assign cmp_tag_o  = rd_tag_i[gnt_q];
  assign cmp_bank_o = bank_q;

endmodule

/* rtl/dcache_data_banks.sv */
// data SRAM banks, one per word offset of the line
// each entry holds the word of every way, writes are byte enabled per way

`include "dcache_params.svh"

module dcache_data_banks
  import dcache_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  dcache_bank_if.bank bank_i
);

  localparam int SETS = 2 ** `DC_IDX_W;

  for (genvar k = 0; k < `DC_BANKS; k++) begin : gen_bank
    word_t [`DC_WAYS-1:0] mem_q [SETS];
    word_t [`DC_WAYS-1:0] rdata_q;

    // byte enabled write per way
    always_ff @(posedge clk_i) begin
      if (bank_i.req[k] && bank_i.we[k]) begin
        for (int j = 0; j < `DC_WAYS; j++) begin
          for (int b = 0; b < `DC_XLEN / 8; b++) begin
            if (bank_i.be[k][j][b]) begin
              mem_q[bank_i.idx[k]][j][8*b +: 8] <= bank_i.wdata[k][j][8*b +: 8];
            end
          end
        end
      end
    end

    // registered read, holds its value until the next read
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        rdata_q <= '0;
      end else if (bank_i.req[k] && !bank_i.we[k]) begin
        rdata_q <= mem_q[bank_i.idx[k]];
      end
    end

    assign bank_i.rdata[k] = rdata_q;
  end

endmodule

/* rtl/dcache_hit_select.sv */
// tag compare and read word select
// builds the hit vector and picks the word of the lowest hitting way

`include "dcache_params.svh"

module dcache_hit_select
  import dcache_pkg::*;
(
  dcache_bank_if.rd  bank_i,
  dcache_tag_if.rd   tag_i,
  input  logic       cmp_en_i,
  input  tag_t       cmp_tag_i,
  input  bank_sel_t  cmp_bank_i,
  output way_mask_t  rd_hit_oh_o,
  output way_mask_t  rd_vld_bits_o,
  output word_t      rd_data_o
);

  localparam int WAY_W = $clog2(`DC_WAYS);

  logic [WAY_W-1:0] hit_way;

  // hits only count in the cycle after a granted read
  for (genvar i = 0; i < `DC_WAYS; i++) begin : gen_cmp
    assign rd_hit_oh_o[i] = cmp_en_i & tag_i.rvld[i] & (tag_i.rtag[i] == cmp_tag_i);
  end

  assign rd_vld_bits_o = tag_i.rvld;

  // lowest way wins, way 0 when nothing hits
  always_comb begin
    hit_way = '0;
    for (int i = `DC_WAYS - 1; i >= 0; i--) begin
      if (rd_hit_oh_o[i]) begin
        hit_way = WAY_W'(i);
      end
    end
  end

  assign rd_data_o = bank_i.rdata[cmp_bank_i][hit_way];

endmodule

/* rtl/dcache_mem.sv */
// top level of the data cache memory core
// arbiter, data banks, tag array and hit select on two internal interfaces

`include "dcache_params.svh"

module dcache_mem
  import dcache_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 rst_ni,
  // read ports, tag one cycle after the ack
  input  port_mask_t           rd_req_i,
  input  port_mask_t           rd_prio_i,
  input  port_mask_t           rd_tag_only_i,
  input  idx_t [`DC_PORTS-1:0] rd_idx_i,
  input  off_t [`DC_PORTS-1:0] rd_off_i,
  input  tag_t [`DC_PORTS-1:0] rd_tag_i,
  output port_mask_t           rd_ack_o,
  output way_mask_t            rd_hit_oh_o,
  output way_mask_t            rd_vld_bits_o,
  output word_t                rd_data_o,
  // cache line fill
  input  logic                 wr_cl_vld_i,
  input  way_mask_t            wr_cl_we_i,
  input  idx_t                 wr_cl_idx_i,
  input  tag_t                 wr_cl_tag_i,
  input  line_t                wr_cl_data_i,
  input  way_mask_t            wr_vld_bits_i,
  // single word write
  input  way_mask_t            wr_req_i,
  input  idx_t                 wr_idx_i,
  input  off_t                 wr_off_i,
  input  word_t                wr_data_i,
  input  word_be_t             wr_be_i,
  output logic                 wr_ack_o
);

  logic      cmp_en;
  tag_t      cmp_tag;
  bank_sel_t cmp_bank;

  dcache_bank_if u_bank_if ();
  dcache_tag_if  u_tag_if ();

  dcache_arbiter u_arbiter (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .rd_req_i      (rd_req_i),
    .rd_prio_i     (rd_prio_i),
    .rd_tag_only_i (rd_tag_only_i),
    .rd_idx_i      (rd_idx_i),
    .rd_off_i      (rd_off_i),
    .rd_tag_i      (rd_tag_i),
    .rd_ack_o      (rd_ack_o),
    .wr_cl_vld_i   (wr_cl_vld_i),
    .wr_cl_we_i    (wr_cl_we_i),
    .wr_cl_idx_i   (wr_cl_idx_i),
    .wr_cl_tag_i   (wr_cl_tag_i),
    .wr_cl_data_i  (wr_cl_data_i),
    .wr_vld_bits_i (wr_vld_bits_i),
    .wr_req_i      (wr_req_i),
    .wr_idx_i      (wr_idx_i),
    .wr_off_i      (wr_off_i),
    .wr_data_i     (wr_data_i),
    .wr_be_i       (wr_be_i),
    .wr_ack_o      (wr_ack_o),
    .bank_o        (u_bank_if.ctrl),
    .tag_o         (u_tag_if.ctrl),
    .cmp_en_o      (cmp_en),
    .cmp_tag_o     (cmp_tag),
    .cmp_bank_o    (cmp_bank)
  );

  dcache_data_banks u_data_banks (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .bank_i (u_bank_if.bank)
  );

  dcache_tag_array u_tag_array (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .tag_i  (u_tag_if.array)
  );

  dcache_hit_select u_hit_select (
    .bank_i        (u_bank_if.rd),
    .tag_i         (u_tag_if.rd),
    .cmp_en_i      (cmp_en),
    .cmp_tag_i     (cmp_tag),
    .cmp_bank_i    (cmp_bank),
    .rd_hit_oh_o   (rd_hit_oh_o),
    .rd_vld_bits_o (rd_vld_bits_o),
    .rd_data_o     (rd_data_o)
  );

endmodule

/* rtl/dcache_mem_if.sv */
// bank interface: per bank request side and per way read data
// tag interface: way mask request side and per way tag/valid read data

`include "dcache_params.svh"

interface dcache_bank_if
  import dcache_pkg::*;
();

  logic [`DC_BANKS-1:0]                 req;
  logic [`DC_BANKS-1:0]                 we;
  idx_t [`DC_BANKS-1:0]                 idx;
  word_be_t [`DC_BANKS-1:0][`DC_WAYS-1:0] be;
  word_t [`DC_BANKS-1:0][`DC_WAYS-1:0]  wdata;
  word_t [`DC_BANKS-1:0][`DC_WAYS-1:0]  rdata;

  modport ctrl (output req, we, idx, be, wdata, input rdata);
  modport bank (input req, we, idx, be, wdata, output rdata);
  modport rd   (input rdata);

endinterface

interface dcache_tag_if
  import dcache_pkg::*;
();

  way_mask_t             req;
  logic                  we;
  idx_t                  addr;
  tag_t                  wtag;
  way_mask_t             wvld;
  tag_t [`DC_WAYS-1:0]   rtag;
  way_mask_t             rvld;

  modport ctrl  (output req, we, addr, wtag, wvld, input rtag, rvld);
  modport array (input req, we, addr, wtag, wvld, output rtag, rvld);
  modport rd    (input rtag, rvld);

endinterface

/* rtl/dcache_params.svh */
// size parameters of the L1 data cache memory core
// ways, read ports, word and line widths, index, tag and offset widths

`ifndef DCACHE_PARAMS_SVH
`define DCACHE_PARAMS_SVH

// associativity and number of read ports
`define DC_WAYS    2
`define DC_PORTS   2

// word and cache line widths
`define DC_XLEN    32
`define DC_LINE_W  128

// words per line, one SRAM bank per word offset
`define DC_BANKS   4

// address split: tag | index | byte offset
`define DC_IDX_W   4
`define DC_TAG_W   8
`define DC_OFF_W   4

// byte address bits below the word
`define DC_ALIGN   2

`endif

/* rtl/dcache_pkg.sv */
// shared types of the data cache memory core
// words, lines, address fields, masks and the bank access kind

`include "dcache_params.svh"

package dcache_pkg;

  // payload
  typedef logic [`DC_XLEN-1:0]   word_t;
  typedef logic [`DC_LINE_W-1:0] line_t;
  typedef logic [`DC_XLEN/8-1:0] word_be_t;

  // address fields
  typedef logic [`DC_TAG_W-1:0]           tag_t;
  typedef logic [`DC_IDX_W-1:0]           idx_t;
  typedef logic [`DC_OFF_W-1:0]           off_t;
  typedef logic [`DC_OFF_W-`DC_ALIGN-1:0] bank_sel_t;

  // one bit per way / per read port
  typedef logic [`DC_WAYS-1:0]  way_mask_t;
  typedef logic [`DC_PORTS-1:0] port_mask_t;

  // what the banks do in a given cycle
  typedef enum logic [2:0] {
    ACC_IDLE,
    ACC_FILL,
    ACC_READ,
    ACC_WORD_WRITE,
    ACC_READ_WORD_WRITE
  } bank_access_e;

endpackage

/* rtl/dcache_tag_array.sv */
// tag array with valid bits, one tag SRAM per way
// valid bits sit in flops so that they clear on reset

`include "dcache_params.svh"

module dcache_tag_array
  import dcache_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_ni,
  dcache_tag_if.array  tag_i
);

  localparam int SETS = 2 ** `DC_IDX_W;

  for (genvar i = 0; i < `DC_WAYS; i++) begin : gen_way
    tag_t             tag_mem_q [SETS];
    logic [SETS-1:0]  vld_q;
    tag_t             rtag_q;
    logic             rvld_q;

    // tag storage, written only by a fill
    always_ff @(posedge clk_i) begin
      if (tag_i.req[i] && tag_i.we) begin
        tag_mem_q[tag_i.addr] <= tag_i.wtag;
      end
    end

    // valid bits and the read registers
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        vld_q  <= '0;
        rtag_q <= '0;
        rvld_q <= 1'b0;
      end else if (tag_i.req[i]) begin
        if (tag_i.we) begin
          vld_q[tag_i.addr] <= tag_i.wvld[i];
        end else begin
          rtag_q <= tag_mem_q[tag_i.addr];
          rvld_q <= vld_q[tag_i.addr];
        end
      end
    end

    assign tag_i.rtag[i] = rtag_q;
    assign tag_i.rvld[i] = rvld_q;
  end

endmodule

/* sim/dcache_trace.txt */
# F/B: way_we idx tag vld_bits line | W: way idx off be data
# R: port tag_only idx off tag exp_hit exp_vld exp_data | D: prio first second
# C: idx rd_off tag_only wr_off way be data exp_wack
D 0 0 1
R 0 0 3 0 12 0 0 0
F 1 3 12 1 44444444333333332222222211111111
R 0 0 3 0 12 1 1 11111111
R 1 0 3 4 12 1 1 22222222
R 0 0 3 8 12 1 1 33333333
R 1 0 3 c 12 1 1 44444444
R 0 0 3 0 13 0 1 0
F 2 5 20 0 aaaaaaaaaaaaaaaaaaaaaaaaaaaaaaaa
R 0 0 5 0 20 0 0 0
F 2 3 34 2 88888888777777776666666655555555
R 1 0 3 4 34 2 3 66666666
R 0 0 3 4 12 1 3 22222222
W 1 3 4 3 0000beef
R 0 0 3 4 12 1 3 2222beef
W 2 3 c c cafe0000
R 1 0 3 c 34 2 3 cafe8888
D 2 1 0
D 0 1 0
D 1 0 1
C 3 4 0 4 1 f 11111111 0
C 3 0 1 0 2 f 99999999 1
C 3 8 0 0 1 1 000000aa 1
R 0 0 3 4 12 1 3 11111111
R 1 0 3 0 34 2 3 99999999
R 0 0 3 0 12 1 3 111111aa
B 1 7 55 1 ddddddddccccccccbbbbbbbbaaaaaaaa
R 0 0 7 8 55 1 1 cccccccc
R 1 1 7 0 55 1 1 0
R 0 0 9 4 00 0 0 0

/* sim/tb_dcache_mem.sv */
// testbench of the data cache memory core
// trace reader, reference model of tags, valid bits and words,
// read, fill, word write, arbitration and collision checks, timeout

`include "dcache_params.svh"

module tb_dcache_mem
  import dcache_pkg::*;
();

  logic clk_i, rst_ni;
  port_mask_t rd_req_i, rd_prio_i, rd_tag_only_i, rd_ack_o;
  idx_t [`DC_PORTS-1:0] rd_idx_i;
  off_t [`DC_PORTS-1:0] rd_off_i;
  tag_t [`DC_PORTS-1:0] rd_tag_i;
  way_mask_t rd_hit_oh_o, rd_vld_bits_o, wr_cl_we_i, wr_vld_bits_i, wr_req_i;
  word_t rd_data_o, wr_data_i;
  logic wr_cl_vld_i, wr_ack_o;
  idx_t wr_cl_idx_i, wr_idx_i;
  tag_t wr_cl_tag_i;
  line_t wr_cl_data_i;
  off_t wr_off_i;
  word_be_t wr_be_i;

  // reference model
  tag_t  ref_tag [`DC_WAYS][16];
  logic  ref_vld [`DC_WAYS][16];
  word_t ref_word [`DC_WAYS][16][`DC_BANKS];
  int    rr_ref;
  logic [31:0] lcg_state;
  int    cyc_cnt, cyc_limit;

  dcache_mem u_dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic value_error(input string msg);
    $display("** Error @%0t: %s", $time, msg);
    $display("ERRORS FOUND");
    $fatal(1);
  endtask

  task automatic run_failure(input string msg);
    $display("%s", msg);
    $display("ERRORS FOUND");
    $fatal(1);
  endtask

  always @(posedge clk_i) begin
    cyc_cnt++;
    if (cyc_cnt > cyc_limit) begin
      $display("run timed out after %0d cycles", cyc_limit);
      $display("ERRORS FOUND");
      $fatal(1);
    end
  end

  // drop every request, scramble the unused operands
  task automatic drive_idle();
    logic [31:0] r;
    r = lcg_next();
    @(posedge clk_i);
    rd_req_i <= '0;
    rd_prio_i <= '0;
    wr_req_i <= '0;
    wr_cl_vld_i <= 1'b0;
    rd_idx_i <= r[7:0];
    rd_off_i <= r[15:8];
    rd_tag_i <= r[31:16];
    wr_data_i <= lcg_next();
  endtask

  function automatic way_mask_t model_hit(input idx_t idx, input tag_t tag);
    way_mask_t h;
    for (int w = 0; w < `DC_WAYS; w++) begin
      h[w] = ref_vld[w][idx] && (ref_tag[w][idx] == tag);
    end
    return h;
  endfunction

  task automatic do_read(input int p, input logic to, input idx_t idx, input off_t off,
                         input tag_t tag, input way_mask_t ehit, input way_mask_t evld,
                         input word_t edata);
    way_mask_t mhit, mvld;
    int w;
    mhit = model_hit(idx, tag);
    mvld = {ref_vld[1][idx], ref_vld[0][idx]};
    w = mhit[0] ? 0 : 1;
    assert (mhit == ehit && mvld == evld &&
            (ehit == 0 || to || ref_word[w][idx][off[3:2]] == edata))
      else run_failure("trace read expectation disagrees with the reference model");
    @(posedge clk_i);
    rd_req_i[p] <= 1'b1;
    rd_tag_only_i[p] <= to;
    rd_idx_i[p] <= idx;
    rd_off_i[p] <= off;
    // a wrong tag in the request cycle, the real one in the cycle after the ack
    rd_tag_i[p] <= ~tag;
    do @(negedge clk_i); while (!rd_ack_o[p]);
    assert (rd_ack_o == port_mask_t'(1 << p)) else value_error("read ack on wrong port");
    rr_ref = (p + 1) % `DC_PORTS;
    @(posedge clk_i);
    rd_req_i <= '0;
    rd_tag_i[p] <= tag;
    @(negedge clk_i);
    assert (rd_hit_oh_o == ehit) else value_error($sformatf("hit %b, expected %b",
                                                            rd_hit_oh_o, ehit));
    assert (rd_vld_bits_o == evld) else value_error("valid bits differ");
    if (ehit != 0 && !to) begin
      assert (rd_data_o == edata) else value_error($sformatf("data %h, expected %h",
                                                             rd_data_o, edata));
    end
    // no read in flight now, the tag is still held
    @(negedge clk_i);
    assert (rd_hit_oh_o == '0) else value_error("hit vector set without a read in flight");
    drive_idle();
  endtask

  task automatic do_fill(input way_mask_t we, input idx_t idx, input tag_t tag,
                         input way_mask_t vld, input line_t data, input logic with_read);
    @(posedge clk_i);
    wr_cl_vld_i <= 1'b1;
    wr_cl_we_i <= we;
    wr_cl_idx_i <= idx;
    wr_cl_tag_i <= tag;
    wr_vld_bits_i <= vld;
    wr_cl_data_i <= data;
    if (with_read) begin
      rd_req_i <= 2'b01;
      rd_tag_only_i <= '0;
    end
    @(negedge clk_i);
    assert (rd_ack_o == '0) else value_error("read acked during a fill");
    for (int w = 0; w < `DC_WAYS; w++) begin
      if (we[w]) begin
        ref_tag[w][idx] = tag;
        ref_vld[w][idx] = vld[w];
        for (int k = 0; k < `DC_BANKS; k++) begin
          ref_word[w][idx][k] = data[32*k +: 32];
        end
      end
    end
    drive_idle();
  endtask

  task automatic update_word(input way_mask_t way, input idx_t idx, input off_t off,
                             input word_be_t be, input word_t data);
    for (int w = 0; w < `DC_WAYS; w++) begin
      for (int b = 0; b < 4; b++) begin
        if (way[w] && be[b]) begin
          ref_word[w][idx][off[3:2]][8*b +: 8] = data[8*b +: 8];
        end
      end
    end
  endtask

  task automatic drive_write(input way_mask_t way, input idx_t idx, input off_t off,
                             input word_be_t be, input word_t data);
    wr_req_i <= way;
    wr_idx_i <= idx;
    wr_off_i <= off;
    wr_be_i <= be;
    wr_data_i <= data;
  endtask

  task automatic do_word_write(input way_mask_t way, input idx_t idx, input off_t off,
                               input word_be_t be, input word_t data);
    @(posedge clk_i);
    drive_write(way, idx, off, be, data);
    do @(negedge clk_i); while (!wr_ack_o);
    update_word(way, idx, off, be, data);
    drive_idle();
  endtask

  // read on port 0 and a word write in the same cycle
  task automatic do_collision(input idx_t idx, input off_t roff, input logic to,
                              input off_t woff, input way_mask_t way, input word_be_t be,
                              input word_t data, input logic ewack);
    assert (ewack == (to || roff[3:2] != woff[3:2]))
      else run_failure("trace collision expectation disagrees with the bank rule");
    @(posedge clk_i);
    rd_req_i <= 2'b01;
    rd_tag_only_i[0] <= to;
    rd_idx_i[0] <= idx;
    rd_off_i[0] <= roff;
    drive_write(way, idx, woff, be, data);
    @(negedge clk_i);
    assert (rd_ack_o == 2'b01) else value_error("read beside a word write not acked");
    assert (wr_ack_o == ewack) else value_error("word write ack wrong on collision");
    rr_ref = 1;
    @(posedge clk_i);
    rd_req_i <= '0;
    if (ewack) begin
      wr_req_i <= '0;
    end else begin
      @(negedge clk_i);
      assert (wr_ack_o) else value_error("held word write not acked after collision");
    end
    update_word(way, idx, woff, be, data);
    drive_idle();
  endtask

  task automatic do_dual(input port_mask_t prio, input int efirst, input int esecond);
    port_mask_t comp;
    int first;
    comp = (prio != 0) ? prio : 2'b11;
    first = comp[rr_ref] ? rr_ref : 1 - rr_ref;
    assert (first == efirst && esecond == 1 - first)
      else run_failure("trace arbitration expectation disagrees with the grant rule");
    @(posedge clk_i);
    rd_req_i <= 2'b11;
    rd_prio_i <= prio;
    rd_tag_only_i <= 2'b11;
    @(negedge clk_i);
    assert (rd_ack_o == port_mask_t'(1 << efirst)) else value_error("first grant wrong");
    @(posedge clk_i);
    rd_req_i[efirst] <= 1'b0;
    @(negedge clk_i);
    assert (rd_ack_o == port_mask_t'(1 << esecond)) else value_error("second grant wrong");
    rr_ref = (esecond + 1) % `DC_PORTS;
    drive_idle();
  endtask

  initial begin
    int fd, n;
    string line;
    byte op;
    logic [127:0] a, b, c, d, e, f, g, h;
    lcg_state = 32'he588;
    cyc_cnt = 0;
    rr_ref = 0;
    fd = $fopen("sim/dcache_trace.txt", "r");
    if (fd == 0) begin
      run_failure("cannot open sim/dcache_trace.txt");
    end
    n = 0;
    while ($fgets(line, fd) != 0) begin
      n++;
    end
    $fclose(fd);
    cyc_limit = 40 * n + 100;
    for (int w = 0; w < `DC_WAYS; w++) begin
      for (int i = 0; i < 16; i++) begin
        ref_vld[w][i] = 1'b0;
      end
    end
    rst_ni = 1'b0;
    rd_req_i = '0;
    rd_prio_i = '0;
    rd_tag_only_i = '0;
    rd_idx_i = '0;
    rd_off_i = '0;
    rd_tag_i = '0;
    wr_cl_vld_i = 1'b0;
    wr_cl_we_i = '0;
    wr_cl_idx_i = '0;
    wr_cl_tag_i = '0;
    wr_cl_data_i = '0;
    wr_vld_bits_i = '0;
    wr_req_i = '0;
    wr_idx_i = '0;
    wr_off_i = '0;
    wr_data_i = '0;
    wr_be_i = '0;
    repeat (4) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    assert (rd_ack_o == '0 && wr_ack_o == 1'b0 && rd_hit_oh_o == '0)
      else value_error("outputs not low after reset");
    fd = $fopen("sim/dcache_trace.txt", "r");
    while ($fgets(line, fd) != 0) begin
      if (line.len() < 2 || line.getc(0) == "#") begin
        continue;
      end
      n = $sscanf(line, "%c %h %h %h %h %h %h %h %h", op, a, b, c, d, e, f, g, h);
      case (op)
        "F": do_fill(way_mask_t'(a), idx_t'(b), tag_t'(c), way_mask_t'(d), e, 1'b0);
        "B": do_fill(way_mask_t'(a), idx_t'(b), tag_t'(c), way_mask_t'(d), e, 1'b1);
        "W": do_word_write(way_mask_t'(a), idx_t'(b), off_t'(c), word_be_t'(d),
                           word_t'(e));
        "R": do_read(int'(a), b[0], idx_t'(c), off_t'(d), tag_t'(e),
                     way_mask_t'(f), way_mask_t'(g), word_t'(h));
        "D": do_dual(port_mask_t'(a), int'(b), int'(c));
        "C": do_collision(idx_t'(a), off_t'(b), c[0], off_t'(d), way_mask_t'(e),
                          word_be_t'(f), word_t'(g), h[0]);
        default: run_failure({"unknown trace operation in line: ", line});
      endcase
    end
    $fclose(fd);
    $display("NO ERRORS");
    $finish;
  end

endmodule

/* tb.f */
+incdir+rtl
rtl/dcache_pkg.sv
rtl/dcache_mem_if.sv
rtl/dcache_arbiter.sv
rtl/dcache_data_banks.sv
rtl/dcache_tag_array.sv
rtl/dcache_hit_select.sv
rtl/dcache_mem.sv
sim/tb_dcache_mem.sv
